// File: logic/kcpu_pkg.sv
/* kcpu register slice definitions
   transfer codes, push mask layout and command opcodes */

package kcpu_pkg;

    // transfer codes as in the tfr/exg postbyte nibble
    typedef enum logic [3:0] {
        REG_D  = 4'h0,
        REG_X  = 4'h1,
        REG_Y  = 4'h2,
        REG_U  = 4'h3,
        REG_S  = 4'h4,
        REG_PC = 4'h5,
        REG_A  = 4'h8,
        REG_B  = 4'h9,
        REG_CC = 4'hA,
        REG_DP = 4'hB
    } reg_code_e; // 6, 7 and C..F read as zero

    typedef enum logic [1:0] {CMD_LD, CMD_TFR, CMD_PSH, CMD_PUL} cmd_op_e;

    typedef logic [7:0] psh_mask_t;

    // push/pull postbyte bit positions
    localparam int PSH_CC    = 0;
    localparam int PSH_A     = 1;
    localparam int PSH_B     = 2;
    localparam int PSH_DP    = 3;
    localparam int PSH_X     = 4;
    localparam int PSH_Y     = 5;
    localparam int PSH_OTHER = 6; // U on the S stack, S on the U stack
    localparam int PSH_PC    = 7;

    localparam psh_mask_t PSH_WIDE = 8'hF0; // bits that move two bytes

endpackage

// File: logic/stack_bus_pkg.sv
/* stack bus definitions
   bus widths, default RAM size and arbiter owner encoding */

package stack_bus_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    // RAM address bits unless the top level overrides it
    localparam int RAM_AW_DEF = 10;

    // last requester served by the arbiter
    typedef enum logic {
        OWN_SEQ  = 1'b0,
        OWN_HOST = 1'b1
    } owner_e;

endpackage

// File: logic/stack_bus_if.sv
/* stack bus, one requester to the arbiter
   req/addr held until a one-cycle gnt, read data one cycle later */

`timescale 1ns/10ps

interface stack_bus_if import stack_bus_pkg::*; ();

    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              gnt;    // single cycle
    logic [DATA_W-1:0] rdata;
    logic              rvalid; // one cycle after gnt on reads

    modport requester (
        output req, we, addr, wdata,
        input  gnt, rdata, rvalid
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output gnt, rdata, rvalid
    );

endinterface

// File: logic/kcpu_regs.sv
/* kcpu register file
   A, B, DP, CC, X, Y, U, S, PC with transfer muxes, push byte select,
   pull byte steering and stack pointer stepping */

`timescale 1ns/10ps

module kcpu_regs import kcpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        up_en,
    input  reg_code_e   up_dst,
    input  logic [15:0] wr_val,
    input  reg_code_e   tfr_src,
    input  psh_mask_t   psh_bit,
    input  logic        psh_hilon,
    input  logic        psh_ussel,
    input  logic        pul_en,
    input  logic        dec_sp,
    input  reg_code_e   rd_sel,
    output logic [15:0] tfr_val,
    output logic [15:0] rd_data,
    output logic [ 7:0] psh_byte,
    output logic [15:0] sp_val
);

logic [ 7:0] a, b, dp, cc;
logic [15:0] x, y, u, s, pc;
logic [15:0] other_sp, wide_src, nx_u, nx_s;
logic [ 7:0] pul_b;

assign sp_val   = psh_ussel ? u : s;
assign other_sp = psh_ussel ? s : u;
assign pul_b    = wr_val[7:0]; // pulled byte rides on the low half

// 8-bit registers come out with FF on top
function automatic logic [15:0] xfer(input reg_code_e code);
    case (code)
        REG_D:   xfer = {a, b};
        REG_X:   xfer = x;
        REG_Y:   xfer = y;
        REG_U:   xfer = u;
        REG_S:   xfer = s;
        REG_PC:  xfer = pc;
        REG_A:   xfer = {8'hFF, a};
        REG_B:   xfer = {8'hFF, b};
        REG_CC:  xfer = {8'hFF, cc};
        REG_DP:  xfer = {8'hFF, dp};
        default: xfer = 16'h0000;
    endcase
endfunction

always_comb begin
    tfr_val = xfer(tfr_src);
    rd_data = xfer(rd_sel);
end

// push byte, psh_bit is one-hot
always_comb begin
    wide_src = psh_bit[PSH_X] ? x :
               psh_bit[PSH_Y] ? y :
               psh_bit[PSH_OTHER] ? other_sp : pc;
    case (1'b1)
        psh_bit[PSH_CC]: psh_byte = cc;
        psh_bit[PSH_A]:  psh_byte = a;
        psh_bit[PSH_B]:  psh_byte = b;
        psh_bit[PSH_DP]: psh_byte = dp;
        default:         psh_byte = psh_hilon ? wide_src[15:8] : wide_src[7:0];
    endcase
end

// U/S next value
always_comb begin
    nx_u = u;
    nx_s = s;
    if (dec_sp || pul_en) begin
        if (psh_ussel)
            nx_u = dec_sp ? u - 16'd1 : u + 16'd1;
        else
            nx_s = dec_sp ? s - 16'd1 : s + 16'd1;
    end
    // pulling the other stack pointer
    if (pul_en && psh_bit[PSH_OTHER]) begin
        if (psh_ussel) begin
            if (psh_hilon) nx_s[15:8] = pul_b;
            else           nx_s[ 7:0] = pul_b;
        end else begin
            if (psh_hilon) nx_u[15:8] = pul_b;
            else           nx_u[ 7:0] = pul_b;
        end
    end
    if (up_en && up_dst == REG_U) nx_u = wr_val; // load beats step
    if (up_en && up_dst == REG_S) nx_s = wr_val;
end

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        a  <= 8'h00;
        b  <= 8'h00;
        dp <= 8'h00;
        cc <= 8'h00;
        x  <= 16'h0000;
        y  <= 16'h0000;
        u  <= 16'h0000;
        s  <= 16'h0000;
        pc <= 16'h0000;
    end else if (cen) begin
        u <= nx_u;
        s <= nx_s;
        if (up_en) begin
            case (up_dst)
                REG_D: begin
                    a <= wr_val[15:8];
                    b <= wr_val[7:0];
                end
                REG_X:   x  <= wr_val;
                REG_Y:   y  <= wr_val;
                REG_PC:  pc <= wr_val;
                REG_A:   a  <= wr_val[7:0];
                REG_B:   b  <= wr_val[7:0];
                REG_CC:  cc <= wr_val[7:0];
                REG_DP:  dp <= wr_val[7:0];
                default: ; // U and S go through nx_u/nx_s
            endcase
        end
        if (pul_en) begin
            case (1'b1)
                psh_bit[PSH_CC]: cc <= pul_b;
                psh_bit[PSH_A]:  a  <= pul_b;
                psh_bit[PSH_B]:  b  <= pul_b;
                psh_bit[PSH_DP]: dp <= pul_b;
                psh_bit[PSH_X]:  if (psh_hilon) x[15:8] <= pul_b; else x[7:0] <= pul_b;
                psh_bit[PSH_Y]:  if (psh_hilon) y[15:8] <= pul_b; else y[7:0] <= pul_b;
                psh_bit[PSH_PC]: if (psh_hilon) pc[15:8] <= pul_b; else pc[7:0] <= pul_b;
                default: ;
            endcase
        end
    end
end

endmodule

// File: logic/stack_seq.sv
/* push/pull command sequencer
   runs ld/tfr in one step, walks the push mask byte by byte over the stack bus */

`timescale 1ns/10ps

module stack_seq import kcpu_pkg::*; import stack_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        cmd_stb,
    input  cmd_op_e     cmd_op,
    input  logic [ 7:0] cmd_sel,
    input  logic        cmd_ussel,
    input  logic [15:0] cmd_data,
    input  logic [15:0] tfr_val,
    input  logic [ 7:0] psh_byte,
    input  logic [15:0] sp_val,
    output logic        busy,
    output logic        done,
    output logic        up_en,
    output reg_code_e   up_dst,
    output logic [15:0] wr_val,
    output reg_code_e   tfr_src,
    output psh_mask_t   psh_bit,
    output logic        psh_hilon,
    output logic        psh_ussel,
    output logic        pul_en,
    output logic        dec_sp,
    stack_bus_if.requester bus
);

typedef enum logic [2:0] {IDLE, PICK, DEC, WRITE, READ, WAIT_DATA, FINISH} state_e;

state_e            state;
psh_mask_t         mask;     // registers still to move
logic              pul_dir;
logic              got_gnt, got_data;
logic [DATA_W-1:0] rd_byte, pul_byte;
logic              accept, gnt_hit, data_hit, is16, last_byte;

assign accept   = cen && cmd_stb && state == IDLE && !busy; // sampled on cen edges only
assign gnt_hit  = bus.gnt || got_gnt;
assign data_hit = bus.rvalid || got_data;
assign pul_byte = bus.rvalid ? bus.rdata : rd_byte;

// push takes the highest bit, pull the lowest
always_comb begin
    psh_bit = '0;
    for (int i = 0; i < 8; i++) begin
        if (mask[i] && (!pul_dir || psh_bit == '0)) psh_bit = psh_mask_t'(1) << i;
    end
end

assign is16      = |(psh_bit & PSH_WIDE);
assign last_byte = !is16 || (pul_dir ? !psh_hilon : psh_hilon); // push ends high, pull ends low

assign up_en   = accept && (cmd_op == CMD_LD || cmd_op == CMD_TFR);
assign up_dst  = reg_code_e'(cmd_sel[3:0]);
assign tfr_src = reg_code_e'(cmd_sel[7:4]);
assign wr_val  = up_en ? (cmd_op == CMD_LD ? cmd_data : tfr_val) : 16'(pul_byte);
assign pul_en  = cen && state == WAIT_DATA && data_hit;
assign dec_sp  = cen && state == DEC;

assign bus.req   = (state == WRITE || state == READ) && !got_gnt;
assign bus.we    = state == WRITE;
assign bus.addr  = sp_val;
assign bus.wdata = psh_byte;

// the bus runs without cen, so keep what arrives during a stall
always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        got_gnt  <= 1'b0;
        got_data <= 1'b0;
    end else begin
        got_gnt  <= (got_gnt || bus.gnt) && !(cen && (state == WRITE || state == READ));
        got_data <= (got_data || bus.rvalid) && !(cen && state == WAIT_DATA);
    end
end

always_ff @(posedge clk) begin
    if (bus.rvalid) rd_byte <= bus.rdata;
end

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        state     <= IDLE;
        mask      <= '0;
        pul_dir   <= 1'b0;
        psh_hilon <= 1'b0;
        psh_ussel <= 1'b0;
        busy      <= 1'b0;
        done      <= 1'b0;
    end else begin
        done <= 1'b0;
        if (done) busy <= 1'b0;
        if (cen) begin
            case (state)
                IDLE: if (accept) begin
                    busy <= 1'b1;
                    if (up_en) begin
                        done <= 1'b1; // ld/tfr wrote on this edge
                    end else begin
                        mask      <= cmd_sel;
                        pul_dir   <= cmd_op == CMD_PUL;
                        psh_ussel <= cmd_ussel;
                        state     <= PICK;
                    end
                end
                PICK: begin
                    if (mask == '0) begin
                        state <= FINISH;
                    end else begin
                        psh_hilon <= pul_dir; // pull starts on the high byte
                        state     <= pul_dir ? READ : DEC;
                    end
                end
                DEC:  state <= WRITE;
                WRITE: if (gnt_hit) begin
                    if (last_byte) begin
                        mask  <= mask & ~psh_bit;
                        state <= PICK;
                    end else begin
                        psh_hilon <= 1'b1;
                        state     <= DEC;
                    end
                end
                READ: if (gnt_hit) state <= WAIT_DATA;
                WAIT_DATA: if (data_hit) begin
                    if (last_byte) begin
                        mask  <= mask & ~psh_bit;
                        state <= PICK;
                    end else begin
                        psh_hilon <= 1'b0;
                        state     <= READ;
                    end
                end
                FINISH: begin
                    done  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end
end

endmodule

// File: logic/bus_arbiter.sv
/* round-robin arbiter for the stack RAM
   grants sequencer or host, routes the winner, returns rvalid on reads */

`timescale 1ns/10ps

module bus_arbiter import stack_bus_pkg::*; #(
    parameter int RAM_AW = RAM_AW_DEF
) (
    input  logic              clk,
    input  logic              rst,
    stack_bus_if.arbiter      seq_bus,
    stack_bus_if.arbiter      host_bus,
    output logic              ram_we,
    output logic [RAM_AW-1:0] ram_addr,
    output logic [DATA_W-1:0] ram_wdata,
    input  logic [DATA_W-1:0] ram_rdata
);

owner_e            last_own; // also the owner of an active grant
logic              gnt_seq, gnt_host, rv_seq, rv_host;
logic              pick_seq, pick_host;
logic [ADDR_W-1:0] sel_addr;

// no new grant while one is on the bus
assign pick_seq  = !(gnt_seq || gnt_host) && seq_bus.req &&
                   (!host_bus.req || last_own == OWN_HOST);
assign pick_host = !(gnt_seq || gnt_host) && host_bus.req && !pick_seq;

always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
        last_own <= OWN_HOST; // sequencer goes first on a tie
        gnt_seq  <= 1'b0;
        gnt_host <= 1'b0;
        rv_seq   <= 1'b0;
        rv_host  <= 1'b0;
    end else begin
        gnt_seq  <= pick_seq;
        gnt_host <= pick_host;
        if (pick_seq)
            last_own <= OWN_SEQ;
        else if (pick_host)
            last_own <= OWN_HOST;
        rv_seq  <= gnt_seq && !seq_bus.we;
        rv_host <= gnt_host && !host_bus.we;
    end
end

assign sel_addr  = last_own == OWN_HOST ? host_bus.addr : seq_bus.addr;
assign ram_addr  = sel_addr[RAM_AW-1:0]; // mirrored over the 16-bit space
assign ram_wdata = last_own == OWN_HOST ? host_bus.wdata : seq_bus.wdata;
assign ram_we    = (gnt_seq && seq_bus.we) || (gnt_host && host_bus.we);

assign seq_bus.gnt     = gnt_seq;
assign seq_bus.rvalid  = rv_seq;
assign seq_bus.rdata   = ram_rdata;
assign host_bus.gnt    = gnt_host;
assign host_bus.rvalid = rv_host;
assign host_bus.rdata  = ram_rdata;

endmodule

// File: logic/stack_ram.sv
/* stack RAM, single port bytes
   registered read, one cycle latency */

`timescale 1ns/10ps

module stack_ram import stack_bus_pkg::*; #(
    parameter int RAM_AW = RAM_AW_DEF
) (
    input  logic              clk,
    input  logic              we,
    input  logic [RAM_AW-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    output logic [DATA_W-1:0] rdata
);

logic [DATA_W-1:0] mem [1 << RAM_AW];

always_ff @(posedge clk) begin
    if (we) mem[addr] <= wdata;
    rdata <= mem[addr]; // old data on a write cycle
end

endmodule

// File: logic/kcpu_stack_top.sv
/* kcpu register and stack slice
   register file, push/pull sequencer and a stack RAM shared with a host port */

`timescale 1ns/10ps

module kcpu_stack_top import kcpu_pkg::*; import stack_bus_pkg::*; #(
    parameter int RAM_AW = RAM_AW_DEF
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              cmd_stb,
    input  cmd_op_e           cmd_op,
    input  logic [ 7:0]       cmd_sel,
    input  logic              cmd_ussel,
    input  logic [15:0]       cmd_data,
    input  reg_code_e         rd_sel,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [ADDR_W-1:0] host_addr,
    input  logic [DATA_W-1:0] host_wdata,
    output logic              busy,
    output logic              done,
    output logic [15:0]       rd_data,
    output logic              host_gnt,
    output logic [DATA_W-1:0] host_rdata,
    output logic              host_rvalid
);

logic              up_en, psh_hilon, psh_ussel, pul_en, dec_sp, ram_we;
reg_code_e         up_dst, tfr_src;
psh_mask_t         psh_bit;
logic [15:0]       wr_val, tfr_val, sp_val;
logic [ 7:0]       psh_byte;
logic [RAM_AW-1:0] ram_addr;
logic [DATA_W-1:0] ram_wdata, ram_rdata;

stack_bus_if seq_bus ();
stack_bus_if host_bus ();

// host side of the bus from plain ports
assign host_bus.req   = host_req;
assign host_bus.we    = host_we;
assign host_bus.addr  = host_addr;
assign host_bus.wdata = host_wdata;
assign host_gnt       = host_bus.gnt;
assign host_rdata     = host_bus.rdata;
assign host_rvalid    = host_bus.rvalid;

kcpu_regs u_regs (
    .clk, .rst, .cen, .up_en, .up_dst, .wr_val, .tfr_src, .psh_bit, .psh_hilon,
    .psh_ussel, .pul_en, .dec_sp, .rd_sel, .tfr_val, .rd_data, .psh_byte, .sp_val
);

stack_seq u_seq (
    .clk, .rst, .cen, .cmd_stb, .cmd_op, .cmd_sel, .cmd_ussel, .cmd_data,
    .tfr_val, .psh_byte, .sp_val, .busy, .done, .up_en, .up_dst, .wr_val,
    .tfr_src, .psh_bit, .psh_hilon, .psh_ussel, .pul_en, .dec_sp, .bus(seq_bus)
);

bus_arbiter #(.RAM_AW(RAM_AW)) u_arb (
    .clk, .rst, .seq_bus, .host_bus, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
);

stack_ram #(.RAM_AW(RAM_AW)) u_ram (
    .clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
);

endmodule

// File: verif/tb_kcpu_stack.sv
/* testbench for the kcpu register and stack slice
   reference model of registers and stack bytes, host traffic beside push/pull */

`timescale 1ns/10ps

module tb_kcpu_stack import kcpu_pkg::*; import stack_bus_pkg::*; ();

localparam int RAM_AW    = 10;
localparam int ROUNDS    = 12;
localparam int N_CMDS    = 40 + ROUNDS * 19;   // ld/tfr phase plus 19 commands per round
localparam int MAX_BYTES = 12;                 // full push mask
localparam int WORST_CYC = 2 * MAX_BYTES * 8 + 64;
localparam int WD_CYCLES = (N_CMDS + 64 + ROUNDS * MAX_BYTES) * WORST_CYC;

logic              clk, rst, cen, cmd_stb, cmd_ussel;
cmd_op_e           cmd_op;
logic [ 7:0]       cmd_sel;
logic [15:0]       cmd_data, rd_data;
reg_code_e         rd_sel;
logic              host_req, host_we, host_gnt, host_rvalid, busy, done;
logic [ADDR_W-1:0] host_addr;
logic [DATA_W-1:0] host_wdata, host_rdata;

// reference model state
logic [ 7:0] m_a, m_b, m_dp, m_cc;
logic [15:0] m_x, m_y, m_u, m_s, m_pc;
logic [ 7:0] m_mem [1 << RAM_AW];

int reg_errs, byte_errs, ctrl_errs, other_errs;
bit cen_rand, sweeping;

kcpu_stack_top #(.RAM_AW(RAM_AW)) UUT (
    .clk, .rst, .cen, .cmd_stb, .cmd_op, .cmd_sel, .cmd_ussel, .cmd_data, .rd_sel,
    .host_req, .host_we, .host_addr, .host_wdata, .busy, .done, .rd_data,
    .host_gnt, .host_rdata, .host_rvalid
);

initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
end

function automatic logic [15:0] model_get(input reg_code_e code);
    case (code)
        REG_D:   return {m_a, m_b};
        REG_X:   return m_x;
        REG_Y:   return m_y;
        REG_U:   return m_u;
        REG_S:   return m_s;
        REG_PC:  return m_pc;
        REG_A:   return {8'hFF, m_a}; // byte registers read with FF on top
        REG_B:   return {8'hFF, m_b};
        REG_CC:  return {8'hFF, m_cc};
        REG_DP:  return {8'hFF, m_dp};
        default: return 16'h0000;
    endcase
endfunction

function automatic void model_set(input reg_code_e code, input logic [15:0] v);
    case (code)
        REG_D: begin
            m_a = v[15:8];
            m_b = v[7:0];
        end
        REG_X:   m_x  = v;
        REG_Y:   m_y  = v;
        REG_U:   m_u  = v;
        REG_S:   m_s  = v;
        REG_PC:  m_pc = v;
        REG_A:   m_a  = v[7:0];
        REG_B:   m_b  = v[7:0];
        REG_CC:  m_cc = v[7:0];
        REG_DP:  m_dp = v[7:0];
        default: ;
    endcase
endfunction

// mask bit to register, bit 6 is the other stack
function automatic reg_code_e mask_code(input int pos, input logic ussel);
    case (pos)
        0:       return REG_CC;
        1:       return REG_A;
        2:       return REG_B;
        3:       return REG_DP;
        4:       return REG_X;
        5:       return REG_Y;
        6:       return ussel ? REG_S : REG_U;
        default: return REG_PC;
    endcase
endfunction

function automatic int byte_count(input logic [7:0] mask);
    return $countones(mask[3:0]) + 2 * $countones(mask[7:4]);
endfunction

function automatic logic [7:0] fill_byte(input logic [RAM_AW-1:0] a);
    return a[7:0] ^ {a[9:8], a[9:8], a[9:8], a[9:8]} ^ 8'h5A;
endfunction

// expected registers and memory after one command
function automatic void apply_cmd(input cmd_op_e op, input logic [7:0] sel,
                                  input logic ussel, input logic [15:0] data);
    logic [15:0] sp, v;
    reg_code_e   code;
    sp = ussel ? m_u : m_s;
    case (op)
        CMD_LD:  model_set(reg_code_e'(sel[3:0]), data);
        CMD_TFR: model_set(reg_code_e'(sel[3:0]), model_get(reg_code_e'(sel[7:4])));
        CMD_PSH: begin
            for (int i = 7; i >= 0; i--) begin
                if (sel[i]) begin
                    code = mask_code(i, ussel);
                    v = model_get(code);
                    sp = sp - 16'd1;
                    m_mem[sp[RAM_AW-1:0]] = v[7:0]; // low byte first
                    if (i >= 4) begin
                        sp = sp - 16'd1;
                        m_mem[sp[RAM_AW-1:0]] = v[15:8];
                    end
                end
            end
        end
        default: begin
            for (int i = 0; i < 8; i++) begin
                if (sel[i]) begin
                    code = mask_code(i, ussel);
                    v = {8'h00, m_mem[sp[RAM_AW-1:0]]};
                    sp = sp + 16'd1;
                    if (i >= 4) begin
                        v = {v[7:0], m_mem[sp[RAM_AW-1:0]]}; // high byte came first
                        sp = sp + 16'd1;
                    end
                    model_set(code, v);
                end
            end
        end
    endcase
    if (op == CMD_PSH || op == CMD_PUL) model_set(ussel ? REG_U : REG_S, sp);
endfunction

task automatic check_reg(input reg_code_e code, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
        reg_errs++;
        $display("** Error @%0t: reg code %h got %h exp %h", $time, code, got, exp);
    end
endtask

task automatic check_byte(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] got,
                          input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
        byte_errs++;
        $display("** Error @%0t: byte at %h got %h exp %h", $time, addr, got, exp);
    end
endtask

task automatic check_ctrl(input logic busy_got, input logic done_got,
                          input logic busy_exp, input logic done_exp);
    if (busy_got !== busy_exp || done_got !== done_exp) begin
        ctrl_errs++;
        $display("** Error @%0t: busy/done got %b/%b exp %b/%b", $time,
                 busy_got, done_got, busy_exp, done_exp);
    end
endtask

task automatic read_reg(input reg_code_e code, output logic [15:0] val);
    @(posedge clk);
    rd_sel <= code;
    @(negedge clk);
    val = rd_data;
endtask

task automatic sweep_regs();
    logic [15:0] val;
    for (int i = 0; i < 16; i++) begin
        read_reg(reg_code_e'(i[3:0]), val);
        check_reg(reg_code_e'(i[3:0]), val, model_get(reg_code_e'(i[3:0])));
    end
endtask

// one host transfer, request held until gnt
task automatic host_access(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
    int cyc;
    bit granted;
    rdata = '0;
    cyc = 0;
    @(posedge clk);
    host_req   <= 1'b1;
    host_we    <= we;
    host_addr  <= addr;
    host_wdata <= wdata;
    do begin
        @(negedge clk);
        cyc++;
    end while (!host_gnt && cyc < 64);
    granted = host_gnt;
    @(posedge clk);
    host_req <= 1'b0;
    if (!granted) begin
        other_errs++;
        $display("host request to %h was not granted within 64 cycles", addr);
    end else if (!we) begin
        @(negedge clk);
        if (!host_rvalid) begin
            other_errs++;
            $display("host read of %h got no rvalid one cycle after gnt", addr);
        end
        rdata = host_rdata;
    end
endtask

// random host traffic kept clear of both stacks
task automatic host_traffic(input int n);
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] d, rb;
    for (int k = 0; k < n; k++) begin
        a = {6'($urandom), 4'h0, 6'($urandom)};
        d = 8'($urandom);
        if ($urandom % 2) begin
            m_mem[a[RAM_AW-1:0]] = d;
            host_access(1'b1, a, d, rb);
        end else begin
            host_access(1'b0, a, 8'h00, rb);
            check_byte(a, rb, m_mem[a[RAM_AW-1:0]]);
        end
    end
endtask

// issue a command, optionally strobe a stray ld while busy
task automatic run_cmd(input cmd_op_e op, input logic [7:0] sel, input logic ussel,
                       input logic [15:0] data, input bit poke);
    int waits;
    @(posedge clk);
    apply_cmd(op, sel, ussel, data);
    cmd_stb   <= 1'b1;
    cmd_op    <= op;
    cmd_sel   <= sel;
    cmd_ussel <= ussel;
    cmd_data  <= data;
    waits = 0;
    do begin
        @(negedge clk);
        waits++;
    end while (!busy);
    if (op == CMD_LD || op == CMD_TFR) begin
        check_ctrl(busy, done, 1'b1, 1'b1); // done right after the write edge
        if (!cen_rand && waits != 2) begin
            ctrl_errs++;
            $display("** Error @%0t: ld/tfr done in cycle %0d after the strobe, exp 2",
                     $time, waits);
        end
        @(posedge clk);
        cmd_stb <= 1'b0;
    end else begin
        check_ctrl(busy, done, 1'b1, 1'b0);
        @(posedge clk);
        if (poke) begin
            cmd_op   <= CMD_LD;
            cmd_sel  <= {4'h0, REG_X};
            cmd_data <= 16'($urandom);
            @(posedge clk);
        end
        cmd_stb <= 1'b0;
        do @(negedge clk); while (!done);
        @(posedge clk);
    end
    wait (!sweeping);
endtask

task automatic load_regs();
    reg_code_e codes [7] = '{REG_A, REG_B, REG_DP, REG_CC, REG_X, REG_Y, REG_PC};
    foreach (codes[i]) run_cmd(CMD_LD, {4'h0, codes[i]}, 1'b0, 16'($urandom), 1'b0);
endtask

// register compare after every done
initial begin : compare
    forever begin
        @(negedge clk);
        if (done) begin
            sweeping = 1'b1;
            sweep_regs();
            sweeping = 1'b0;
        end
    end
end

initial begin : cen_drive
    cen = 1'b1;
    forever begin
        @(posedge clk);
        cen <= cen_rand ? ($urandom % 3 != 0) : 1'b1;
    end
end

initial begin : watchdog
    #(WD_CYCLES * 8);
    $display("watchdog expired after %0d cycles, a command or host access hung", WD_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
end

initial begin : stimulus
    logic [15:0]       sp0, got;
    logic [ADDR_W-1:0] a;
    logic [DATA_W-1:0] rb;
    logic [ 7:0]       mask;
    reg_code_e         spc, oc;
    logic              us;
    bit                poke;
    void'($urandom(32'hf9a6));
    rst = 1'b1;
    cmd_stb = 1'b0;
    cmd_op = CMD_LD;
    cmd_sel = 8'h00;
    cmd_ussel = 1'b0;
    cmd_data = 16'h0000;
    rd_sel = REG_D;
    host_req = 1'b0;
    host_we = 1'b0;
    host_addr = '0;
    host_wdata = '0;
    {m_a, m_b, m_dp, m_cc} = '0;
    {m_x, m_y, m_u, m_s, m_pc} = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_ctrl(busy, done, 1'b0, 1'b0);
    sweep_regs(); // all zero out of reset
    for (int i = 0; i < 64; i++) begin
        m_mem[i] = fill_byte(10'(i));
        host_access(1'b1, 16'(i), fill_byte(10'(i)), rb);
    end
    // loads to every code, then random transfers
    for (int i = 0; i < 16; i++) run_cmd(CMD_LD, 8'(i), 1'b0, 16'($urandom), 1'b0);
    for (int i = 0; i < 24; i++) begin
        cen_rand = i >= 12;
        run_cmd(CMD_TFR, 8'($urandom), 1'b0, 16'h0000, 1'b0);
    end
    for (int r = 0; r < ROUNDS; r++) begin
        cen_rand = r >= ROUNDS / 2;
        poke = r % 3 == 1;
        us   = 1'(r % 2);
        spc  = us ? REG_U : REG_S;
        oc   = us ? REG_S : REG_U;
        run_cmd(CMD_LD, {4'h0, REG_S}, 1'b0, {6'($urandom), 10'h300}, 1'b0);
        run_cmd(CMD_LD, {4'h0, REG_U}, 1'b0, {6'($urandom), 10'h200}, 1'b0);
        load_regs();
        mask = 8'($urandom);
        sp0 = model_get(spc);
        fork
            run_cmd(CMD_PSH, mask, us, 16'h0000, poke);
            host_traffic(6);
        join
        read_reg(spc, got);
        check_reg(spc, got, sp0 - 16'(byte_count(mask)));
        for (int k = 1; k <= byte_count(mask); k++) begin
            a = sp0 - 16'(k); // push order
            host_access(1'b0, a, 8'h00, rb);
            check_byte(a, rb, m_mem[a[RAM_AW-1:0]]);
        end
        load_regs(); // clobber before the pull
        run_cmd(CMD_LD, {4'h0, oc}, 1'b0, 16'($urandom), 1'b0);
        fork
            run_cmd(CMD_PUL, mask, us, 16'h0000, poke);
            host_traffic(6);
        join
        read_reg(spc, got);
        check_reg(spc, got, sp0);
    end
    cen_rand = 1'b0;
    repeat (4) @(posedge clk);
    $display("errors: reg %0d, byte %0d, ctrl %0d, other %0d",
             reg_errs, byte_errs, ctrl_errs, other_errs);
    if (reg_errs + byte_errs + ctrl_errs + other_errs == 0)
        $display("TESTBENCH PASSED");
    else
        $display("TESTBENCH FAILED");
    $finish;
end

endmodule

// File: list.f
logic/kcpu_pkg.sv
logic/stack_bus_pkg.sv
logic/stack_bus_if.sv
logic/kcpu_regs.sv
logic/stack_seq.sv
logic/bus_arbiter.sv
logic/stack_ram.sv
logic/kcpu_stack_top.sv
verif/tb_kcpu_stack.sv

// File: Bender.yml
package:
  name: kcpu_stack

sources:
  - logic/kcpu_pkg.sv
  - logic/stack_bus_pkg.sv
  - logic/stack_bus_if.sv
  - logic/kcpu_regs.sv
  - logic/stack_seq.sv
  - logic/bus_arbiter.sv
  - logic/stack_ram.sv
  - logic/kcpu_stack_top.sv
  - target: test
    files:
      - verif/tb_kcpu_stack.sv
